/* hdl/crc_stage_params.svh */
//////////////////////////////////////////////////////////////////////
// crc stage parameters: word widths, footer slots, history sizing
//////////////////////////////////////////////////////////////////////
`ifndef CRC_STAGE_PARAMS_SVH
`define CRC_STAGE_PARAMS_SVH

// stream word
`define TLV_DATA_W      64
`define TLV_STRB_W      8

// word counter saturates once the top bit is set
`define WORD_NUM_W      14

// footer word slots
`define RAW_CKSUM_WORD  5
`define NVME_CKSUM_WORD 12

// header fields
`define SEQ_NUM_W       8
`define FRAME_NUM_W     11

// stamped into the last footer word on a failed check
`define CRC_ERR_CODE    8'h2C

// frame history
`define HIST_DEPTH      8
`define HIST_ENTRY_W    96

`endif

/* hdl/crc_stage_pkg.sv */
//////////////////////////////////////////////////////////////////////
// crc stage types: TLV types, metadata types and operating modes
//////////////////////////////////////////////////////////////////////
package crc_stage_pkg;

  // TLV types that the stage acts on
  typedef enum logic [7:0] {
    CMD            = 8'd1,
    DATA           = 8'd3,
    FTR            = 8'd5,
    FRMD_USER_NULL = 8'd8,
    FRMD_USER_PI16 = 8'd9,
    FRMD_USER_PI64 = 8'd10
  } tlv_type_e;

  // metadata type, bits 1:0 of command word 1
  typedef enum logic [1:0] {
    MD_NO_CRC = 2'd0,
    MD_CRC64  = 2'd1
  } md_type_e;

  // operating mode of the stage
  typedef enum logic [1:0] {
    MODE_BYPASS = 2'd0,
    MODE_GEN    = 2'd1,
    MODE_CHK    = 2'd2
  } crc_mode_e;

endpackage

/* hdl/tlv_ingress.sv */
//////////////////////////////////////////////////////////////////////
// tlv ingress: input FIFO read control, stage-1 register, word count
//////////////////////////////////////////////////////////////////////
`include "crc_stage_params.svh"

module tlv_ingress (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_empty,
  input  logic                      out_afull,
  input  logic [`TLV_DATA_W-1:0]    in_tdata,
  input  crc_stage_pkg::tlv_type_e  in_typen,
  input  logic                      in_sot,
  input  logic                      in_eot,
  input  logic [`TLV_STRB_W-1:0]    in_tstrb,
  output logic                      in_rd,
  output logic                      s1_valid,
  output logic [`TLV_DATA_W-1:0]    s1_tdata,
  output crc_stage_pkg::tlv_type_e  s1_typen,
  output logic                      s1_sot,
  output logic                      s1_eot,
  output logic [`TLV_STRB_W-1:0]    s1_tstrb,
  output logic [`WORD_NUM_W-1:0]    s1_word_num
);
  import crc_stage_pkg::*;

  // afull leaves room for the two words already in flight
  assign in_rd = ~in_empty & ~out_afull;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      // stream opens on a TLV boundary
      s1_eot      <= 1'b1;
      s1_word_num <= '0;
    end else begin
      s1_valid <= in_rd;
      if (in_rd) begin
        s1_eot <= in_eot;
      end
      if (in_rd && in_sot) begin
        s1_word_num <= '0;
      end else if (in_rd && !s1_word_num[`WORD_NUM_W-1]) begin
        s1_word_num <= s1_word_num + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_rd) begin
      s1_tdata <= in_tdata;
      s1_typen <= in_typen;
      s1_sot   <= in_sot;
      s1_tstrb <= in_tstrb;
    end
  end

  // a new TLV starts exactly after the previous eot
  a_tlv_framing: assert property (
    @(posedge clk) disable iff (!rst_n) in_rd |-> (in_sot == s1_eot)
  );

endmodule

/* hdl/tlv_decode.sv */
//////////////////////////////////////////////////////////////////////
// tlv decode: command and metadata capture, CRC data tap, enables
//////////////////////////////////////////////////////////////////////
`include "crc_stage_params.svh"

module tlv_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  crc_stage_pkg::crc_mode_e  mode,
  input  logic                      gen_en,
  input  logic                      chk_en,
  input  logic                      s1_valid,
  input  logic [`TLV_DATA_W-1:0]    s1_tdata,
  input  crc_stage_pkg::tlv_type_e  s1_typen,
  input  logic                      s1_sot,
  input  logic [`TLV_STRB_W-1:0]    s1_tstrb,
  input  logic [`WORD_NUM_W-1:0]    s1_word_num,
  output logic                      data_valid,
  output logic [`TLV_DATA_W-1:0]    data,
  output logic [`TLV_STRB_W-1:0]    data_vbytes,
  output logic                      crc_init,
  output logic                      crc_sof,
  output logic                      gen_raw,
  output logic                      gen_nvme,
  output logic                      chk_raw,
  output logic                      chk_nvme,
  output logic                      trace_on,
  output logic [`SEQ_NUM_W-1:0]     seq_num,
  output logic [`FRAME_NUM_W-1:0]   frame_num
);
  import crc_stage_pkg::*;

  md_type_e   md_type;
  tlv_type_e  frmd_type;
  logic       hdr_cap;
  logic       raw_sel;
  logic       nvme_sel;
  logic       gen_on;
  logic       chk_on;

  // header word of a DATA or FTR TLV
  assign hdr_cap = s1_valid && s1_sot && (s1_typen == DATA || s1_typen == FTR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_valid  <= 1'b0;
      data_vbytes <= '0;
      crc_init    <= 1'b0;
      crc_sof     <= 1'b0;
      md_type     <= MD_NO_CRC;
      trace_on    <= 1'b0;
      // no metadata TLV seen yet
      frmd_type   <= CMD;
      seq_num     <= '0;
      frame_num   <= '0;
    end else begin
      data_valid  <= 1'b0;
      data_vbytes <= '0;
      crc_init    <= 1'b0;
      crc_sof     <= 1'b0;
      if (s1_valid) begin
        case (s1_typen)
          CMD: begin
            if (s1_word_num == `WORD_NUM_W'(1)) begin
              md_type  <= md_type_e'(s1_tdata[1:0]);
              trace_on <= s1_tdata[2];
            end
          end
          DATA: begin
            data_valid  <= ~s1_sot;
            crc_init    <= s1_sot;
            crc_sof     <= (s1_word_num == `WORD_NUM_W'(1));
            data_vbytes <= s1_sot ? '0 : s1_tstrb;
          end
          FRMD_USER_NULL, FRMD_USER_PI16, FRMD_USER_PI64: begin
            frmd_type <= s1_typen;
          end
          default: ;
        endcase
      end
      if (hdr_cap) begin
        seq_num   <= s1_tdata[`SEQ_NUM_W-1:0];
        frame_num <= s1_tdata[`SEQ_NUM_W +: `FRAME_NUM_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s1_typen == DATA) begin
      data <= s1_tdata;
    end
  end

  // which footer checksum the frame carries
  assign raw_sel  = (frmd_type == FRMD_USER_NULL) ||
                    (frmd_type == FRMD_USER_PI64 && md_type == MD_CRC64);
  assign nvme_sel = (frmd_type == FRMD_USER_PI16);

  assign gen_on = (mode == MODE_GEN) && gen_en;
  assign chk_on = (mode == MODE_CHK) && chk_en;

  assign gen_raw  = gen_on && raw_sel;
  assign gen_nvme = gen_on && nvme_sel;
  assign chk_raw  = chk_on && raw_sel;
  assign chk_nvme = chk_on && nvme_sel;

endmodule

/* hdl/ftr_process.sv */
//////////////////////////////////////////////////////////////////////
// footer processing: checksum insert or compare, error stamp, output
//////////////////////////////////////////////////////////////////////
`include "crc_stage_params.svh"

module ftr_process (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s1_valid,
  input  logic [`TLV_DATA_W-1:0]    s1_tdata,
  input  crc_stage_pkg::tlv_type_e  s1_typen,
  input  logic                      s1_sot,
  input  logic                      s1_eot,
  input  logic [`TLV_STRB_W-1:0]    s1_tstrb,
  input  logic [`WORD_NUM_W-1:0]    s1_word_num,
  input  logic [`TLV_DATA_W-1:0]    crc64,
  input  logic [15:0]               crc16t,
  input  logic                      gen_raw,
  input  logic                      gen_nvme,
  input  logic                      chk_raw,
  input  logic                      chk_nvme,
  input  logic [`FRAME_NUM_W-1:0]   frame_num,
  output logic                      out_wr,
  output logic [`TLV_DATA_W-1:0]    out_tdata,
  output crc_stage_pkg::tlv_type_e  out_typen,
  output logic                      out_sot,
  output logic                      out_eot,
  output logic [`TLV_STRB_W-1:0]    out_tstrb,
  output logic [`TLV_DATA_W-1:0]    crc_result,
  output logic                      raw_good,
  output logic                      raw_err,
  output logic                      nvme_good,
  output logic                      nvme_err,
  output logic                      chk_active,
  output logic                      any_err
);
  import crc_stage_pkg::*;

  logic                    is_ftr;
  logic                    raw_slot;
  logic                    nvme_slot;
  logic                    raw_match;
  logic                    nvme_match;
  logic                    stamp_err;
  logic [`TLV_DATA_W-1:0]  ftr_word;

  assign is_ftr    = s1_valid && (s1_typen == FTR);
  assign raw_slot  = (s1_word_num == `WORD_NUM_W'(`RAW_CKSUM_WORD));
  assign nvme_slot = (s1_word_num == `WORD_NUM_W'(`NVME_CKSUM_WORD));

  assign raw_match  = (s1_tdata == crc64);
  assign nvme_match = (s1_tdata[`TLV_DATA_W-1 -: 16] == crc16t);

  // only a footer with no earlier error code gets stamped
  assign stamp_err = s1_eot && (raw_err || nvme_err) && (s1_tdata[7:0] == 8'd0);

  always_comb begin
    ftr_word = s1_tdata;
    if (raw_slot && gen_raw) begin
      ftr_word = crc64;
    end else if (nvme_slot && gen_nvme) begin
      ftr_word[`TLV_DATA_W-1 -: 16] = crc16t;
    end else if (stamp_err) begin
      ftr_word[7:0]                = `CRC_ERR_CODE;
      ftr_word[8 +: `FRAME_NUM_W] = frame_num;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_wr     <= 1'b0;
      crc_result <= '0;
      raw_good   <= 1'b0;
      raw_err    <= 1'b0;
      nvme_good  <= 1'b0;
      nvme_err   <= 1'b0;
      any_err    <= 1'b0;
    end else begin
      out_wr <= is_ftr;
      if (is_ftr) begin
        if (raw_slot) begin
          raw_good <= chk_raw & raw_match;
          raw_err  <= chk_raw & ~raw_match;
        end
        if (nvme_slot) begin
          nvme_good <= chk_nvme & nvme_match;
          nvme_err  <= chk_nvme & ~nvme_match;
        end
        if (raw_slot && gen_raw) begin
          crc_result <= crc64;
        end else if (nvme_slot && gen_nvme) begin
          crc_result <= {{(`TLV_DATA_W-16){1'b0}}, crc16t};
        end
        // frame error status goes on to the history
        if (s1_eot) begin
          any_err   <= raw_err | nvme_err;
          raw_good  <= 1'b0;
          raw_err   <= 1'b0;
          nvme_good <= 1'b0;
          nvme_err  <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (is_ftr) begin
      out_tdata <= ftr_word;
      out_typen <= s1_typen;
      out_sot   <= s1_sot;
      out_eot   <= s1_eot;
      out_tstrb <= s1_tstrb;
    end
  end

  assign chk_active = chk_raw | chk_nvme;

  // every footer starts with all check flags clear
  a_flags_clear_at_sot: assert property (
    @(posedge clk) disable iff (!rst_n)
      is_ftr && s1_sot |-> !(raw_good || raw_err || nvme_good || nvme_err)
  );

endmodule

/* hdl/cksum_events.sv */
//////////////////////////////////////////////////////////////////////
// checksum events: single-cycle trace pulses on check results
//////////////////////////////////////////////////////////////////////
module cksum_events (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  trace_on,
  input  logic  raw_good,
  input  logic  raw_err,
  input  logic  nvme_good,
  input  logic  nvme_err,
  output logic  raw_good_ev,
  output logic  raw_err_ev,
  output logic  nvme_good_ev,
  output logic  nvme_err_ev
);

  logic [3:0] flags;
  logic [3:0] flags_q;
  logic [3:0] ev;

  assign flags = {nvme_err, nvme_good, raw_err, raw_good};

  // rising edge of each flag while tracing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      ev      <= '0;
    end else begin
      flags_q <= flags;
      ev      <= flags & ~flags_q & {4{trace_on}};
    end
  end

  assign raw_good_ev  = ev[0];
  assign raw_err_ev   = ev[1];
  assign nvme_good_ev = ev[2];
  assign nvme_err_ev  = ev[3];

endmodule

/* hdl/crc_history.sv */
//////////////////////////////////////////////////////////////////////
// crc history: eight-entry log written at each frame footer end
//////////////////////////////////////////////////////////////////////
`include "crc_stage_params.svh"

module crc_history (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      out_wr,
  input  logic                      out_eot,
  input  crc_stage_pkg::tlv_type_e  out_typen,
  input  logic [`TLV_DATA_W-1:0]    crc_result,
  input  logic                      chk_active,
  input  logic                      any_err,
  input  logic [`FRAME_NUM_W-1:0]   frame_num,
  input  logic [`SEQ_NUM_W-1:0]     seq_num,
  output logic [`HIST_ENTRY_W-1:0]  hist [`HIST_DEPTH]
);
  import crc_stage_pkg::*;

  localparam int PTR_W  = $clog2(`HIST_DEPTH);
  localparam int USED_W = 2 + `FRAME_NUM_W + `SEQ_NUM_W + `TLV_DATA_W;

  logic              hist_wr;
  logic [PTR_W-1:0]  wr_ptr;
  logic [USED_W-1:0] entry;

  assign hist_wr = out_wr && out_eot && (out_typen == FTR);

  // err, active, frame, seq, result from the top down
  assign entry = {any_err, chk_active, frame_num, seq_num, crc_result};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      for (int i = 0; i < `HIST_DEPTH; i++) begin
        hist[i] <= '0;
      end
    end else if (hist_wr) begin
      hist[wr_ptr] <= `HIST_ENTRY_W'(entry);
      wr_ptr       <= wr_ptr + 1'b1;
    end
  end

endmodule

/* hdl/crc_stage.sv */
//////////////////////////////////////////////////////////////////////
// crc stage top: checksum generate or check on a TLV stream
//////////////////////////////////////////////////////////////////////
`include "crc_stage_params.svh"

module crc_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  crc_stage_pkg::crc_mode_e  mode,
  input  logic                      gen_en,
  input  logic                      chk_en,
  input  logic                      in_empty,
  input  logic [`TLV_DATA_W-1:0]    in_tdata,
  input  crc_stage_pkg::tlv_type_e  in_typen,
  input  logic                      in_sot,
  input  logic                      in_eot,
  input  logic [`TLV_STRB_W-1:0]    in_tstrb,
  output logic                      in_rd,
  input  logic                      out_afull,
  output logic                      out_wr,
  output logic [`TLV_DATA_W-1:0]    out_tdata,
  output crc_stage_pkg::tlv_type_e  out_typen,
  output logic                      out_sot,
  output logic                      out_eot,
  output logic [`TLV_STRB_W-1:0]    out_tstrb,
  input  logic [`TLV_DATA_W-1:0]    crc64,
  input  logic [15:0]               crc16t,
  output logic                      data_valid,
  output logic [`TLV_DATA_W-1:0]    data,
  output logic [`TLV_STRB_W-1:0]    data_vbytes,
  output logic                      crc_init,
  output logic                      crc_sof,
  output logic                      raw_good_ev,
  output logic                      raw_err_ev,
  output logic                      nvme_good_ev,
  output logic                      nvme_err_ev,
  output logic [`HIST_ENTRY_W-1:0]  hist [`HIST_DEPTH]
);
  import crc_stage_pkg::*;

  logic                     s1_valid;
  logic [`TLV_DATA_W-1:0]   s1_tdata;
  tlv_type_e                s1_typen;
  logic                     s1_sot;
  logic                     s1_eot;
  logic [`TLV_STRB_W-1:0]   s1_tstrb;
  logic [`WORD_NUM_W-1:0]   s1_word_num;
  logic                     gen_raw;
  logic                     gen_nvme;
  logic                     chk_raw;
  logic                     chk_nvme;
  logic                     trace_on;
  logic [`SEQ_NUM_W-1:0]    seq_num;
  logic [`FRAME_NUM_W-1:0]  frame_num;
  logic [`TLV_DATA_W-1:0]   crc_result;
  logic                     raw_good;
  logic                     raw_err;
  logic                     nvme_good;
  logic                     nvme_err;
  logic                     chk_active;
  logic                     any_err;

  tlv_ingress u_ingress (
    .clk, .rst_n, .in_empty, .out_afull, .in_tdata, .in_typen, .in_sot, .in_eot,
    .in_tstrb, .in_rd, .s1_valid, .s1_tdata, .s1_typen, .s1_sot, .s1_eot, .s1_tstrb,
    .s1_word_num
  );

  tlv_decode u_decode (
    .clk, .rst_n, .mode, .gen_en, .chk_en, .s1_valid, .s1_tdata, .s1_typen, .s1_sot,
    .s1_tstrb, .s1_word_num, .data_valid, .data, .data_vbytes, .crc_init, .crc_sof,
    .gen_raw, .gen_nvme, .chk_raw, .chk_nvme, .trace_on, .seq_num, .frame_num
  );

  ftr_process u_ftr (
    .clk, .rst_n, .s1_valid, .s1_tdata, .s1_typen, .s1_sot, .s1_eot, .s1_tstrb,
    .s1_word_num, .crc64, .crc16t, .gen_raw, .gen_nvme, .chk_raw, .chk_nvme, .frame_num,
    .out_wr, .out_tdata, .out_typen, .out_sot, .out_eot, .out_tstrb, .crc_result,
    .raw_good, .raw_err, .nvme_good, .nvme_err, .chk_active, .any_err
  );

  cksum_events u_events (
    .clk, .rst_n, .trace_on, .raw_good, .raw_err, .nvme_good, .nvme_err,
    .raw_good_ev, .raw_err_ev, .nvme_good_ev, .nvme_err_ev
  );

  crc_history u_history (
    .clk, .rst_n, .out_wr, .out_eot, .out_typen, .crc_result, .chk_active, .any_err,
    .frame_num, .seq_num, .hist
  );

endmodule

/* tb/crc_stage_model.svh */
//////////////////////////////////////////////////////////////////////
// crc stage reference model: footer edits, checks, history entries
//////////////////////////////////////////////////////////////////////
`ifndef CRC_STAGE_MODEL_SVH
`define CRC_STAGE_MODEL_SVH

// frames that carry the raw 64-bit checksum
function automatic logic raw_selected(input tlv_type_e md, input md_type_e mdt);
  return (md == FRMD_USER_NULL) || (md == FRMD_USER_PI64 && mdt == MD_CRC64);
endfunction

// nvme slot only holds crc16t in its top 16 bits
function automatic logic cksum_ok(input int idx, input logic [63:0] w,
                                  input logic [63:0] c64, input logic [15:0] c16);
  if (idx == `RAW_CKSUM_WORD) begin
    return w == c64;
  end
  return w[63:48] == c16;
endfunction

function automatic logic [63:0] footer_word(input int idx, input logic [63:0] w,
    input logic ins_raw, input logic ins_nvme, input logic stamp,
    input logic [63:0] c64, input logic [15:0] c16, input logic [10:0] fnum);
  logic [63:0] r;
  r = w;
  if (idx == `RAW_CKSUM_WORD && ins_raw) begin
    r = c64;
  end else if (idx == `NVME_CKSUM_WORD && ins_nvme) begin
    r[63:48] = c16;
  end else if (stamp && w[7:0] == 8'h00) begin
    // an error code already present is kept
    r[7:0]  = `CRC_ERR_CODE;
    r[18:8] = fnum;
  end
  return r;
endfunction

function automatic logic [`HIST_ENTRY_W-1:0] hist_entry(input logic err, input logic active,
    input logic [10:0] fnum, input logic [7:0] seq, input logic [63:0] res);
  logic [`HIST_ENTRY_W-1:0] e;
  e        = '0;
  e[63:0]  = res;
  e[71:64] = seq;
  e[82:72] = fnum;
  e[83]    = active;
  e[84]    = err;
  return e;
endfunction

`endif

/* tb/crc_stage_tb.sv */
//////////////////////////////////////////////////////////////////////
// crc stage testbench: random TLV frames checked against a model
//////////////////////////////////////////////////////////////////////
`include "crc_stage_params.svh"

module crc_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import crc_stage_pkg::*;

  localparam int FTR_WORDS   = 14;
  localparam int MODE_FRAMES = 6;
  localparam int NUM_FRAMES  = 3 * MODE_FRAMES;

  `include "crc_stage_model.svh"

  logic                      clk;
  logic                      rst_n;
  crc_mode_e                 mode;
  logic                      gen_en, chk_en;
  logic                      in_empty, in_sot, in_eot, in_rd, out_afull;
  logic                      out_wr, out_sot, out_eot;
  logic                      data_valid, crc_init, crc_sof;
  logic [`TLV_DATA_W-1:0]    in_tdata, out_tdata, crc64, data;
  tlv_type_e                 in_typen, out_typen;
  logic [`TLV_STRB_W-1:0]    in_tstrb, out_tstrb, data_vbytes;
  logic [15:0]               crc16t;
  logic                      raw_good_ev, raw_err_ev, nvme_good_ev, nvme_err_ev;
  logic [`HIST_ENTRY_W-1:0]  hist [`HIST_DEPTH];

  // {typen, sot, eot, tstrb, tdata, crc64, crc16t}
  logic [161:0]              stim_q[$];
  // {sot, eot, tstrb, tdata}
  logic [73:0]               out_q[$];
  // {init, sof, vbytes, data}
  logic [73:0]               tap_q[$];
  logic [3:0]                ev_q[$];
  logic [`HIST_ENTRY_W-1:0]  hist_exp [`HIST_DEPTH];
  int                        hist_ptr;
  logic [63:0]               crc_res;
  int                        errors;
  integer                    seed = 67;

  crc_stage DUT (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic push_word(input tlv_type_e t, input logic sot, input logic eot,
                           input logic [7:0] strb, input logic [63:0] d,
                           input logic [63:0] c64, input logic [15:0] c16);
    stim_q.push_back({t, sot, eot, strb, d, c64, c16});
  endtask

  // builds one frame of CMD, metadata, DATA and a 14-word FTR with predicted outputs
  task automatic build_frame(input crc_mode_e m);
    logic [63:0] pay [FTR_WORDS];
    logic [63:0] c64;
    logic [63:0] w;
    logic [15:0] c16;
    logic [7:0]  seq;
    logic [7:0]  strb;
    logic [10:0] fnum;
    logic        trace;
    logic        raw_s;
    logic        nvme_s;
    logic        failed;
    logic [3:0]  code;
    md_type_e    mdt;
    tlv_type_e   md;
    int          ndata;
    c64   = rand64();
    c16   = 16'($random(seed));
    seq   = 8'($random(seed));
    fnum  = 11'($random(seed));
    trace = 1'($random(seed));
    mdt   = ($random(seed) & 1) ? MD_CRC64 : MD_NO_CRC;
    case ($unsigned($random(seed)) % 3)
      0:       md = FRMD_USER_NULL;
      1:       md = FRMD_USER_PI16;
      default: md = FRMD_USER_PI64;
    endcase
    ndata  = 1 + $unsigned($random(seed)) % 4;
    raw_s  = raw_selected(md, mdt);
    nvme_s = (md == FRMD_USER_PI16);
    push_word(CMD, 1'b1, 1'b0, 8'hFF, rand64(), c64, c16);
    w = rand64();
    w[2:0] = {trace, mdt};
    push_word(CMD, 1'b0, 1'b1, 8'hFF, w, c64, c16);
    push_word(md, 1'b1, 1'b0, 8'hFF, rand64(), c64, c16);
    push_word(md, 1'b0, 1'b1, 8'hFF, rand64(), c64, c16);
    // header carries seq and frame number
    w = rand64();
    w[18:0] = {fnum, seq};
    push_word(DATA, 1'b1, 1'b0, 8'hFF, w, c64, c16);
    tap_q.push_back({1'b1, 1'b0, 8'h00, 64'd0});
    for (int i = 1; i <= ndata; i++) begin
      w    = rand64();
      strb = 8'($random(seed));
      push_word(DATA, 1'b0, i == ndata, strb, w, c64, c16);
      tap_q.push_back({1'b0, i == 1, strb, w});
    end
    for (int k = 0; k < FTR_WORDS; k++) begin
      pay[k] = rand64();
    end
    pay[0][18:0] = {fnum, seq};
    if ($random(seed) & 1) begin
      pay[`RAW_CKSUM_WORD] = c64;
    end
    if ($random(seed) & 1) begin
      pay[`NVME_CKSUM_WORD][63:48] = c16;
    end
    if ($random(seed) & 1) begin
      pay[FTR_WORDS-1][7:0] = 8'h00;
    end
    failed = 1'b0;
    for (int k = 0; k < FTR_WORDS; k++) begin
      strb = 8'($random(seed));
      push_word(FTR, k == 0, k == FTR_WORDS - 1, strb, pay[k], c64, c16);
      if (m == MODE_CHK && ((k == `RAW_CKSUM_WORD && raw_s) ||
                            (k == `NVME_CKSUM_WORD && nvme_s))) begin
        code   = cksum_ok(k, pay[k], c64, c16) ? 4'b0001 : 4'b0010;
        failed = failed | code[1];
        if (k == `NVME_CKSUM_WORD) begin
          code = code << 2;
        end
        if (trace) begin
          ev_q.push_back(code);
        end
      end
      w = footer_word(k, pay[k], m == MODE_GEN && raw_s, m == MODE_GEN && nvme_s,
                      failed && k == FTR_WORDS - 1, c64, c16, fnum);
      out_q.push_back({k == 0, k == FTR_WORDS - 1, strb, w});
    end
    if (m == MODE_GEN && raw_s) begin
      crc_res = c64;
    end
    if (m == MODE_GEN && nvme_s) begin
      crc_res = {48'd0, c16};
    end
    hist_exp[hist_ptr] = hist_entry(failed, m == MODE_CHK && (raw_s || nvme_s),
                                    fnum, seq, crc_res);
    hist_ptr = (hist_ptr + 1) % `HIST_DEPTH;
  endtask

  task automatic check_history();
    for (int i = 0; i < `HIST_DEPTH; i++) begin
      assert (hist[i] == hist_exp[i]) else begin
        errors++;
        $display("[ERROR] hist[%0d]: got %h, expected %h", i, hist[i], hist_exp[i]);
      end
    end
  endtask

  task automatic run_mode(input crc_mode_e m);
    @(negedge clk);
    mode = m;
    @(posedge clk);
    for (int i = 0; i < MODE_FRAMES; i++) begin
      build_frame(m);
    end
    while (stim_q.size() != 0 || out_q.size() != 0) begin
      @(posedge clk);
    end
    // trailing pulses and the last history write
    repeat (4) @(posedge clk);
    check_history();
  endtask

  // input FIFO and CRC engine
  always @(negedge clk) begin
    logic [161:0] w;
    if (in_rd) begin
      assert (!in_empty && !out_afull) else begin
        errors++;
        $display("input FIFO read while empty or while the output FIFO was almost full");
      end
      if (stim_q.size() != 0) begin
        stim_q.delete(0);
      end
    end
    out_afull = ($random(seed) & 3) == 0;
    in_empty  = (stim_q.size() == 0) || (($random(seed) & 3) == 0);
    if (stim_q.size() != 0) begin
      w        = stim_q[0];
      in_typen = tlv_type_e'(w[161:154]);
      in_sot   = w[153];
      in_eot   = w[152];
      in_tstrb = w[151:144];
      in_tdata = w[143:80];
      crc64    = w[79:16];
      crc16t   = w[15:0];
    end
  end

  // output FIFO, data tap and trace pulses
  always @(negedge clk) begin
    logic [73:0] e;
    logic [73:0] t;
    logic [3:0]  ev;
    logic [3:0]  ev_exp;
    if (out_wr) begin
      assert (out_q.size() != 0) else begin
        errors++;
        $display("unexpected write to the output FIFO, data %h", out_tdata);
      end
      if (out_q.size() != 0) begin
        e = out_q.pop_front();
        assert (out_tdata == e[63:0]) else begin
          errors++;
          $display("[ERROR] out_tdata: got %h, expected %h", out_tdata, e[63:0]);
        end
        assert ({out_sot, out_eot, out_tstrb} == e[73:64]) else begin
          errors++;
          $display("[ERROR] {out_sot,out_eot,out_tstrb}: got %h, expected %h",
                   {out_sot, out_eot, out_tstrb}, e[73:64]);
        end
        assert (out_typen == FTR) else begin
          errors++;
          $display("[ERROR] out_typen: got %h, expected %h", out_typen, FTR);
        end
      end
    end
    if (data_valid || crc_init) begin
      assert (tap_q.size() != 0) else begin
        errors++;
        $display("data tap active with no DATA word pending, data %h", data);
      end
      if (tap_q.size() != 0) begin
        t = tap_q.pop_front();
        assert ({crc_init, data_valid} == {t[73], ~t[73]}) else begin
          errors++;
          $display("[ERROR] {crc_init,data_valid}: got %h, expected %h",
                   {crc_init, data_valid}, {t[73], ~t[73]});
        end
        assert ({crc_sof, data_vbytes} == t[72:64] && (t[73] || data == t[63:0])) else begin
          errors++;
          $display("[ERROR] {crc_sof,data_vbytes,data}: got %h, expected %h",
                   {crc_sof, data_vbytes, data}, t[72:0]);
        end
      end
    end
    ev = {nvme_err_ev, nvme_good_ev, raw_err_ev, raw_good_ev};
    if (ev != 4'd0) begin
      assert (ev_q.size() != 0) else begin
        errors++;
        $display("trace pulse %h with no traced check pending", ev);
      end
      if (ev_q.size() != 0) begin
        ev_exp = ev_q.pop_front();
        assert (ev == ev_exp) else begin
          errors++;
          $display("[ERROR] {nvme_err,nvme_good,raw_err,raw_good}_ev: got %h, expected %h",
                   ev, ev_exp);
        end
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    mode      = MODE_BYPASS;
    gen_en    = 1'b1;
    chk_en    = 1'b1;
    in_empty  = 1'b1;
    out_afull = 1'b0;
    in_tdata  = '0;
    in_typen  = CMD;
    in_sot    = 1'b0;
    in_eot    = 1'b0;
    in_tstrb  = '0;
    crc64     = '0;
    crc16t    = '0;
    errors    = 0;
    hist_ptr  = 0;
    crc_res   = '0;
    for (int i = 0; i < `HIST_DEPTH; i++) begin
      hist_exp[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_mode(MODE_BYPASS);
    run_mode(MODE_GEN);
    run_mode(MODE_CHK);
    assert (tap_q.size() == 0 && ev_q.size() == 0) else begin
      errors++;
      $display("missing data tap words (%0d) or trace pulses (%0d)",
               tap_q.size(), ev_q.size());
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // each frame drains well within 400 cycles even under heavy back-pressure
  initial begin
    repeat (NUM_FRAMES * 400) @(posedge clk);
    $display("timeout: the stream did not drain in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* crc_stage.f */
+incdir+hdl
+incdir+tb
hdl/crc_stage_pkg.sv
hdl/tlv_ingress.sv
hdl/tlv_decode.sv
hdl/ftr_process.sv
hdl/cksum_events.sv
hdl/crc_history.sv
hdl/crc_stage.sv
tb/crc_stage_tb.sv

/* Bender.yml */
package:
  name: crc_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/crc_stage_pkg.sv
      - hdl/tlv_ingress.sv
      - hdl/tlv_decode.sv
      - hdl/ftr_process.sv
      - hdl/cksum_events.sv
      - hdl/crc_history.sv
      - hdl/crc_stage.sv
  - target: test
    include_dirs:
      - hdl
      - tb
    files:
      - tb/crc_stage_tb.sv
